//--- verification/fetch_stimulus.txt
# M addr data err is a memory word. J n target redirects after n consumed instructions.
# E data err is the next expected instruction with 16-bit ones zero-extended.
# Reset path with 32-bit and mixed lengths
M 80000000 00500093 0
M 80000004 00a00113 0
M 80000008 81934505 0
M 8000000c 05050020 1
M 80000010 45018082 0
M 80000014 00100073 1
# Halfword-aligned target
M 80000100 0513dead 0
M 80000104 458500c5 0
M 80000108 02a00593 1
M 8000010c 00014601 0
# Word-aligned target
M 80000200 00000013 0
M 80000204 08134781 0
M 80000208 900200f0 0
J 7 80000102
J 12 80000200
E 00500093 0
E 00a00113 0
E 00004505 0
E 00208193 1
E 00000505 1
E 00008082 0
E 00004501 0
E 00c50513 0
E 00004585 0
E 02a00593 1
E 00004601 0
E 00000001 0
E 00000013 0
E 00004781 0
E 00f00813 0
E 00009002 0

//--- sources.f
rtl/fetch_pkg.sv
rtl/fetch_req_fsm.sv
rtl/fetch_addr_counter.sv
rtl/fetch_buffer.sv
rtl/fetch_stage.sv
verification/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module fetch_tb -Mdir obj_dir

out=$(./obj_dir/Vfetch_tb 2>&1) || true
echo "$out"

if grep -qF "** PASS **" <<< "$out"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

//--- verification/fetch_tb.sv
/*
 * Fetch stage testbench
 * Memory model with random grant delay, redirects and decode stalls
 * from the stimulus file, delivered instructions checked in order
 */
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

    localparam int clk_period_c   = 40;
    localparam int drive_delay_c  = 2;    // Inputs change just after the edge
    localparam int instr_budget_c = 200;  // Watchdog cycles per instruction

    logic              g_clk;
    logic              g_resetn;
    cf_t               cf;
    logic              cf_ack;
    logic              imem_req;
    logic [xlen_c-1:0] imem_addr;
    logic              imem_gnt;
    logic              imem_error;
    logic [xlen_c-1:0] imem_rdata;
    logic              s0_flush;
    logic              s1_busy;
    dec_out_t          s1;

    logic [xlen_c:0]   mem [logic [xlen_c-1:0]]; // {err, data} per word address
    logic [xlen_c:0]   exp_q [$];                // {err, data} in decode order
    logic [63:0]       jmp_q [$];                // {count, target}
    int                n_exp;
    int                n_done;                   // Instructions consumed
    int                gnt_wait;                 // Waiting cycles left before gnt
    int                seed_rc;
    logic              granted;                  // Request accepted at next edge
    logic              req_waiting;
    logic              redirected;               // cf accepted at next edge
    logic              req_seen;
    logic [xlen_c-1:0] rsp_addr;                 // Word due one cycle after gnt
    logic [xlen_c-1:0] wait_addr;                // Address of a request still waiting

    fetch_stage #(
        .pc_reset_value (32'h8000_0000)
    ) u_fetch_stage (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf         (cf),
        .cf_ack     (cf_ack),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_error (imem_error),
        .imem_rdata (imem_rdata),
        .s0_flush   (s0_flush),
        .s1_busy    (s1_busy),
        .s1         (s1)
    );

    always #(clk_period_c / 2) g_clk = ~g_clk;

    // --------------------------------------------------
    // Error reporting and memory lookup

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        stop_on_error($sformatf("Mismatch %s expected %0h actual %0h", name, exp_v, act_v));
    endtask

    function automatic logic [xlen_c:0] mem_word(input logic [xlen_c-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {1'b0, ~addr};  // Unlisted words
    endfunction

    task automatic read_stimulus();
        int                fd;
        int                rc;
        int                n;
        int                e;
        string             kind;
        string             rest;
        logic [xlen_c-1:0] a;
        logic [xlen_c-1:0] d;
        fd = $fopen("verification/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            stop_on_error("Cannot open verification/fetch_stimulus.txt");
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "M") begin
                rc = $fscanf(fd, "%h %h %d", a, d, e);
                mem[a] = {e[0], d};
            end else if (kind == "J") begin
                rc = $fscanf(fd, "%d %h", n, a);
                jmp_q.push_back({n, a});
            end else if (kind == "E") begin
                rc = $fscanf(fd, "%h %d", d, e);
                exp_q.push_back({e[0], d});
            end else if (kind == "#") begin
                rc = $fgets(rest, fd);            // Comment line
            end else begin
                stop_on_error({"Unknown line kind in stimulus file: ", kind});
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // Per-cycle sampling at negedge, driving after posedge

    task automatic sample_edge();
        logic [xlen_c:0] got;
        logic [xlen_c:0] exp_v;
        // Waiting request keeps req and address until granted
        if (req_waiting) begin
            assert (imem_req && imem_addr == wait_addr)
                else stop_on_error("Request dropped or moved before its grant");
        end
        granted     = imem_req && imem_gnt;
        req_waiting = imem_req && !imem_gnt;
        redirected  = cf.req && cf_ack;
        wait_addr   = imem_addr;
        if (granted) rsp_addr = imem_addr;
        // cf_ack low only while a request waits for its grant
        assert (cf_ack == !req_waiting)
            else report_mismatch("cf_ack", !req_waiting, cf_ack);
        if (imem_req && !req_seen) begin
            req_seen = 1'b1;
            assert (imem_addr == 32'h8000_0000)
                else report_mismatch("first_req_addr", 64'h8000_0000, imem_addr);
        end
        if (s1.valid && !s1_busy) begin
            got   = {s1.error, s1.data};
            exp_v = exp_q.pop_front();
            n_done++;
            assert (got == exp_v)
                else report_mismatch($sformatf("instr_%0d {err,data}", n_done), exp_v, got);
        end
    endtask

    task automatic drive_inputs();
        logic [xlen_c:0]   word;
        logic [xlen_c-1:0] noise;
        logic [63:0]       jmp;
        noise = $urandom;
        word  = granted ? mem_word(rsp_addr) : {noise[7], noise}; // Noise unless rsp due
        imem_rdata = word[xlen_c-1:0];
        imem_error = word[xlen_c];
        // Grant after 0 to 2 waiting cycles
        if (granted) begin
            gnt_wait = $urandom % 3;
        end else if (req_waiting && gnt_wait > 0) begin
            gnt_wait--;
        end
        imem_gnt = (gnt_wait == 0);
        if (redirected) begin
            cf.req   = 1'b0;
            s0_flush = 1'b0;
        end else if (!cf.req && jmp_q.size() > 0 && n_done >= int'(jmp_q[0][63:32])) begin
            jmp       = jmp_q.pop_front();
            cf.req    = 1'b1;                     // Held until cf_ack
            cf.target = jmp[31:0];
            s0_flush  = 1'b1;
        end
        s1_busy = cf.req || (($urandom % 100) < 30); // Decode waits out a redirect
    endtask

    initial begin
        seed_rc     = $urandom(32'hf10a);
        g_clk       = 1'b0;
        g_resetn    = 1'b0;
        cf          = '0;
        imem_gnt    = 1'b0;
        imem_error  = 1'b0;
        imem_rdata  = '0;
        s0_flush    = 1'b0;
        s1_busy     = 1'b0;
        n_done      = 0;
        req_seen    = 1'b0;
        req_waiting = 1'b0;
        read_stimulus();
        n_exp = exp_q.size();
        repeat (4) begin
            @(posedge g_clk);
            #drive_delay_c;
            assert ({imem_req, s1.valid} == 2'b00)
                else report_mismatch("reset_req_valid", 64'h0, {imem_req, s1.valid});
        end
        g_resetn = 1'b1;
        gnt_wait = $urandom % 3;
        imem_gnt = (gnt_wait == 0);
        while (exp_q.size() > 0) begin
            @(negedge g_clk);
            sample_edge();
            @(posedge g_clk);
            #drive_delay_c;
            drive_inputs();
        end
        $display("** PASS **");
        $finish;
    end

    // Watchdog
    initial begin
        wait (n_exp > 0);
        repeat (n_exp * instr_budget_c) @(posedge g_clk);
        stop_on_error($sformatf("Timeout: fetch stalled after %0d of %0d instructions",
                                n_done, n_exp));
    end

endmodule

//--- rtl/fetch_stage.sv
/*
 * Instruction fetch stage
 * Word reads to instruction memory, redirects, halfword packing
 * into 16/32-bit instructions for decode
 */
`timescale 1ns/100ps

module fetch_stage import fetch_pkg::*; #(
    parameter logic [xlen_c-1:0] pc_reset_value = 32'h8000_0000
) (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  cf_t               cf,         // Control flow change
    output logic              cf_ack,
    output logic              imem_req,
    output logic [xlen_c-1:0] imem_addr,
    input  logic              imem_gnt,
    input  logic              imem_error,
    input  logic [xlen_c-1:0] imem_rdata,
    input  logic              s0_flush,
    input  logic              s1_busy,    // Decode stall
    output dec_out_t          s1
);

    logic       cf_take;
    logic       req_take;
    buf_load_t  load;
    logic [2:0] n_depth;

    // --------------------------------------------------
    // Submodules

    fetch_req_fsm u_req_fsm (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf_req     (cf.req),
        .cf_half    (cf.target[1]),
        .imem_gnt   (imem_gnt),
        .imem_error (imem_error),
        .imem_rdata (imem_rdata),
        .n_depth    (n_depth),
        .imem_req   (imem_req),
        .cf_ack     (cf_ack),
        .cf_take    (cf_take),
        .req_take   (req_take),
        .load       (load)
    );

    fetch_addr_counter #(
        .pc_reset_value (pc_reset_value)
    ) u_addr_counter (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_take   (cf_take),
        .cf_target (cf.target),
        .req_take  (req_take),
        .imem_addr (imem_addr)
    );

    fetch_buffer u_buffer (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .flush    (s0_flush),
        .load     (load),
        .consume  (!s1_busy),   // Gated with valid inside
        .out      (s1),
        .n_depth  (n_depth)
    );

endmodule

//--- rtl/fetch_buffer.sv
/*
 * Fetch halfword buffer
 * Three halfword slots with per-slot error bits, hands whole 16 or
 * 32-bit instructions to decode and reports its next depth
 */
`timescale 1ns/100ps

module fetch_buffer import fetch_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       flush,    // Empty now, this cycle's load ignored
    input  buf_load_t  load,
    input  logic       consume,  // Decode can take the head
    output dec_out_t   out,
    output logic [2:0] n_depth   // Depth after this cycle
);

    logic [15:0] hw_q [3];   // Slot 0 is the head
    logic [2:0]  err_q;
    logic [2:0]  depth_q;    // Halfwords held

    logic [15:0] n_hw [3];
    logic [2:0]  n_err;
    instr_len_e  len;
    logic [1:0]  pop_n;      // Halfwords leaving
    logic [1:0]  ld_n;       // Halfwords arriving
    logic [2:0]  rem;        // Depth after the pop

    // --------------------------------------------------
    // Head decode

    always_comb begin
        if (depth_q == 3'd0) begin
            len = LEN_NONE;
        end else if (hw_q[0][1:0] != 2'b11) begin
            len = LEN_16;
        end else begin
            len = LEN_32;
        end
    end

    // Whole instruction present
    assign out.valid = (len == LEN_16) || (len == LEN_32 && depth_q >= 3'd2);

    always_comb begin
        if (len == LEN_32) begin
            out.data  = {hw_q[1], hw_q[0]};
            out.error = err_q[0] | err_q[1];   // Either half bad
        end else begin
            out.data  = {16'h0000, hw_q[0]};   // Zero-extend compressed
            out.error = err_q[0];
        end
    end

    // --------------------------------------------------
    // Depth bookkeeping

    always_comb begin
        pop_n = 2'd0;
        if (consume && out.valid) begin
            pop_n = (len == LEN_32) ? 2'd2 : 2'd1;
        end
    end

    assign ld_n    = load.load4 ? 2'd2 : (load.load2 ? 2'd1 : 2'd0);
    assign rem     = depth_q - {1'b0, pop_n};
    assign n_depth = flush ? 3'd0 : rem + {1'b0, ld_n};

    // --------------------------------------------------
    // Slot contents

    always_comb begin
        n_hw  = hw_q;
        n_err = err_q;
        // Shift survivors down to the head
        for (int i = 0; i < 3; i++) begin
            if (i + pop_n < 3) begin
                n_hw[i]  = hw_q[i + pop_n];
                n_err[i] = err_q[i + pop_n];
            end
        end
        // Append behind the survivors
        for (int i = 0; i < 3; i++) begin
            if (load.load4 && i == rem) begin
                n_hw[i]  = load.data[15:0];
                n_err[i] = load.err;
            end
            if (load.load4 && i == rem + 3'd1) begin
                n_hw[i]  = load.data[31:16];
                n_err[i] = load.err;
            end
            if (load.load2 && i == rem) begin
                n_hw[i]  = load.data[31:16];   // Target is the upper half
                n_err[i] = load.err;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        hw_q  <= n_hw;
        err_q <= n_err;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth_q <= 3'd0;
        end else begin
            depth_q <= n_depth;
        end
    end

    // FSM must never request into a full buffer
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        depth_q <= 3'd3);

endmodule

//--- rtl/fetch_addr_counter.sv
/*
 * Fetch address counter
 * Word-aligned fetch address, loaded on redirect, +4 per granted request
 */
`timescale 1ns/100ps

module fetch_addr_counter import fetch_pkg::*; #(
    parameter logic [xlen_c-1:0] pc_reset_value = 32'h8000_0000
) (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              cf_take,    // Redirect accepted
    input  logic [xlen_c-1:0] cf_target,
    input  logic              req_take,   // Request accepted
    output logic [xlen_c-1:0] imem_addr
);

    logic [xlen_c-1:0] addr_q;
    logic [xlen_c-1:0] next_seq; // Next sequential word

    assign next_seq  = addr_q + xlen_c'(4);
    assign imem_addr = addr_q;

    // --------------------------------------------------
    // Address update, redirect wins over advance

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            addr_q <= pc_reset_value;
        end else if (cf_take) begin
            addr_q <= {cf_target[xlen_c-1:2], 2'b00}; // Fetch containing word
        end else if (req_take) begin
            addr_q <= next_seq;
        end
    end

    // Bus only sees word addresses
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        imem_addr[1:0] == 2'b00);

endmodule

//--- rtl/fetch_req_fsm.sv
/*
 * Fetch request FSM
 * Raises word reads on the instruction bus, acks control flow changes
 * and marks each returning word as kept, dropped or upper-half only
 */
`timescale 1ns/100ps

module fetch_req_fsm import fetch_pkg::*; (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              cf_req,     // Redirect request
    input  logic              cf_half,    // Target bit 1
    input  logic              imem_gnt,
    input  logic              imem_error,
    input  logic [xlen_c-1:0] imem_rdata,
    input  logic [2:0]        n_depth,    // Buffer depth after this cycle
    output logic              imem_req,
    output logic              cf_ack,
    output logic              cf_take,    // Redirect accepted
    output logic              req_take,   // Request accepted
    output buf_load_t         load
);

    fetch_state_e state_q;
    fetch_state_e n_state;
    logic         room;    // Space for one more word
    logic         drop_q;  // Response due now is from the old path
    logic         mis_q;   // Next kept response starts mid-word
    logic         keep;    // Response due now goes to the buffer

    // --------------------------------------------------
    // Bus events

    assign imem_req = (state_q == ST_REQ);
    assign req_take = imem_req && imem_gnt;
    assign cf_ack   = !imem_req || imem_gnt; // Idle, or request leaving now
    assign cf_take  = cf_req && cf_ack;

    // Worst case a word adds two halfwords to three slots
    assign room = (n_depth <= 3'd1);

    always_comb begin
        n_state = state_q;
        case (state_q)
            ST_IDLE: if (room) n_state = ST_REQ;
            ST_REQ:  if (imem_gnt) n_state = ST_RSP;
            ST_RSP:  n_state = room ? ST_REQ : ST_IDLE; // Depth counts this rsp
            default: n_state = ST_IDLE;
        endcase
    end

    // --------------------------------------------------
    // Response handling

    // Stale if redirected at grant or right now
    assign keep = (state_q == ST_RSP) && !drop_q && !cf_take;

    assign load.load4 = keep && !mis_q;
    assign load.load2 = keep &&  mis_q;
    assign load.err   = imem_error;
    assign load.data  = imem_rdata;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q <= ST_IDLE;
            drop_q  <= 1'b0;
            mis_q   <= 1'b0;
        end else begin
            state_q <= n_state;
            drop_q  <= cf_take;             // Applies to rsp one cycle on
            if (cf_take) begin
                mis_q <= cf_half;           // Halfword-aligned target
            end else if (load.load2) begin
                mis_q <= 1'b0;              // First word of new path taken
            end
        end
    end

    // Request held until granted
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        imem_req && !imem_gnt |=> imem_req);

    // Single outstanding, granted word still fits behind what is held
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        req_take |-> n_depth <= 3'd1);

endmodule

//--- rtl/fetch_pkg.sv
/*
 * Fetch stage shared definitions
 * Widths, FSM states, length codes and the structs passed between
 * the request FSM, the address counter and the halfword buffer
 */
package fetch_pkg;

    // Data and address width
    parameter int xlen_c = 32;

    // Request FSM states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0, // Nothing pending
        ST_REQ  = 2'd1, // imem_req high, waiting on gnt
        ST_RSP  = 2'd2  // Granted, rdata due this cycle
    } fetch_state_e;

    // Length of the instruction at the buffer head
    typedef enum logic [1:0] {
        LEN_NONE = 2'd0, // Buffer empty
        LEN_16   = 2'd1, // Compressed
        LEN_32   = 2'd2  // Low two bits are 11
    } instr_len_e;

    // Control flow change
    typedef struct packed {
        logic              req;
        logic [xlen_c-1:0] target;
    } cf_t;

    // Buffer write for this cycle
    typedef struct packed {
        logic              load4; // Whole word
        logic              load2; // Upper halfword only
        logic              err;
        logic [xlen_c-1:0] data;
    } buf_load_t;

    // To decode
    typedef struct packed {
        logic              valid;
        logic              error;
        logic [xlen_c-1:0] data;  // 16-bit instructions zero-extended
    } dec_out_t;

endpackage
